//--- exc_cfg.svh
`ifndef EXC_CFG_SVH
`define EXC_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// Width of one CP0 word as seen by mtc0 and mfc0
`define EXC_DATA_W 32

// Program counter width of the core
`define EXC_ADDR_W 16

// CP0 register number field of mtc0 and mfc0
`define CP0_REG_W 5

//////////////////////////////////////////////////////////////////////
// CP0 register map and handler entry
//////////////////////////////////////////////////////////////////////

`define CP0_STATUS 5'd12
`define CP0_CAUSE  5'd13
`define CP0_EPC    5'd14

// General exception vector
`define EXC_VECTOR 16'h0180

`endif

//--- exc_pkg.sv
`default_nettype none

`include "exc_cfg.svh"

package exc_pkg;

    //////////////////////////////////////////////////////////////////////
    // Exception codes
    //////////////////////////////////////////////////////////////////////

    // Values follow the MIPS Cause.ExcCode field where one exists
    typedef enum logic [4:0] {
        EXC_INTERRUPT = 5'd0,
        EXC_SYSCALL   = 5'd8,
        EXC_ILLEGAL   = 5'd10,
        EXC_OVERFLOW  = 5'd12,
        EXC_TRAP      = 5'd13,
        // Not real MIPS codes, kept out of the architectural range
        EXC_ERET      = 5'd30,
        EXC_NONE      = 5'd31
    } exc_code_e;

    // Exception flags raised by the commit slot
    typedef struct packed {
        logic syscall;
        logic illegal;
        logic trap;
        logic overflow;
        logic eret;
    } exc_mask_t;

    //////////////////////////////////////////////////////////////////////
    // CP0 register layouts
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [7:0]  im;        // Interrupt mask
        logic [5:0]  rsvd_lo;
        logic        exl;       // Exception level
        logic        ie;        // Global interrupt enable
    } cp0_status_t;

    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [7:0]  ip;        // Pending interrupts, sampled from irq
        logic        rsvd_7;
        logic [4:0]  exc_code;
        logic [1:0]  rsvd_lo;
    } cp0_cause_t;

    // One mtc0 word, decoded by register number
    typedef union packed {
        cp0_status_t status;
        cp0_cause_t  cause;
    } cp0_word_u;

    // Flush request towards fetch
    typedef struct packed {
        logic                   flush;
        logic [`EXC_ADDR_W-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

//--- cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "exc_cfg.svh"

module cp0_regs
(
    input  logic                   clk,
    input  logic                   rst_n,

    // mtc0 from writeback
    input  logic                   we,
    input  logic [`CP0_REG_W-1:0]  waddr,
    input  logic [`EXC_DATA_W-1:0] wdata,

    // External interrupt lines
    input  logic [7:0]             irq,

    // Decision of the exception handler for this cycle
    input  exc_pkg::exc_code_e     exception,
    input  logic [`EXC_ADDR_W-1:0] pc,

    // mfc0 read port
    input  logic [`CP0_REG_W-1:0]  raddr,
    output logic [`EXC_DATA_W-1:0] rdata,

    // Live register state
    output exc_pkg::cp0_status_t   status,
    output exc_pkg::cp0_cause_t    cause,
    output logic [`EXC_ADDR_W-1:0] epc
);

    exc_pkg::cp0_word_u wword;
    logic               take_exc;
    logic               take_eret;

    // Same bits, two layouts
    assign wword = wdata;

    // Eret is an exit, everything else but none is an entry
    assign take_eret = (exception == exc_pkg::EXC_ERET);
    assign take_exc  = (exception != exc_pkg::EXC_NONE) && !take_eret;

    //////////////////////////////////////////////////////////////////////
    // Register update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            status <= '0;
            cause  <= '0;
            epc    <= '0;
        end
        else
        begin
            // Pending bits follow the interrupt lines
            cause.ip <= irq;

            // Writeback, writable fields only
            if (we)
            begin
                case (waddr)
                    `CP0_STATUS:
                    begin
                        status.im  <= wword.status.im;
                        status.exl <= wword.status.exl;
                        status.ie  <= wword.status.ie;
                    end
                    `CP0_CAUSE:
                    begin
                        cause.exc_code <= wword.cause.exc_code;
                    end
                    `CP0_EPC:
                    begin
                        epc <= wdata[`EXC_ADDR_W-1:0];
                    end
                    default:
                    begin
                    end
                endcase
            end

            // Exception entry and exit win over writeback
            if (take_exc)
            begin
                epc            <= pc;
                cause.exc_code <= exception;
                status.exl     <= 1'b1;
            end
            else if (take_eret)
            begin
                status.exl <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // mfc0 read mux
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (raddr)
            `CP0_STATUS: rdata = status;
            `CP0_CAUSE:  rdata = cause;
            // EPC zero extended to a full word
            `CP0_EPC:    rdata = {{(`EXC_DATA_W-`EXC_ADDR_W){1'b0}}, epc};
            default:     rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- exception_handler.sv
`timescale 1ns/1ps
`default_nettype none

`include "exc_cfg.svh"

module exception_handler
(
    input  exc_pkg::cp0_status_t   status,
    input  exc_pkg::cp0_cause_t    cause,
    input  exc_pkg::exc_mask_t     exc_mask,
    input  logic [`EXC_ADDR_W-1:0] pc,
    output exc_pkg::exc_code_e     exception,
    output logic                   mem_disable
);

    logic int_req;

    // Pending and unmasked, outside a handler, globally enabled
    assign int_req = ((cause.ip & status.im) != 8'h00) && !status.exl && status.ie;

    //////////////////////////////////////////////////////////////////////
    // Priority select
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        exception = exc_pkg::EXC_NONE;
        // Zero pc marks a bubble
        if (pc != '0)
        begin
            if (int_req)
                exception = exc_pkg::EXC_INTERRUPT;
            else if (exc_mask.syscall)
                exception = exc_pkg::EXC_SYSCALL;
            else if (exc_mask.illegal)
                exception = exc_pkg::EXC_ILLEGAL;
            else if (exc_mask.trap)
                exception = exc_pkg::EXC_TRAP;
            else if (exc_mask.overflow)
                exception = exc_pkg::EXC_OVERFLOW;
            else if (exc_mask.eret)
                exception = exc_pkg::EXC_ERET;
        end
    end

    // Block the memory stage for any synchronous flag
    assign mem_disable = (exc_mask != '0);

endmodule

`default_nettype wire

//--- exception_redirect.sv
`timescale 1ns/1ps
`default_nettype none

`include "exc_cfg.svh"

module exception_redirect
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  exc_pkg::exc_code_e     exception,
    input  logic [`EXC_ADDR_W-1:0] epc,
    output exc_pkg::redirect_t     redirect
);

    logic                   flush_q;
    logic [`EXC_ADDR_W-1:0] target_q;
    logic                   hit;

    assign hit = (exception != exc_pkg::EXC_NONE);

    //////////////////////////////////////////////////////////////////////
    // Flush strobe and target
    //////////////////////////////////////////////////////////////////////

    // One cycle pulse after each exception cycle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            flush_q <= 1'b0;
        else
            flush_q <= hit;
    end

    // Eret returns to the EPC still held before this edge
    always_ff @(posedge clk)
    begin
        if (hit)
        begin
            if (exception == exc_pkg::EXC_ERET)
                target_q <= epc;
            else
                target_q <= `EXC_VECTOR;
        end
    end

    assign redirect.flush  = flush_q;
    assign redirect.target = target_q;

endmodule

`default_nettype wire

//--- exc_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exc_cfg.svh"

module exc_unit
(
    input  logic                   clk,
    input  logic                   rst_n,

    // Writeback mtc0
    input  logic                   cp0_we,
    input  logic [`CP0_REG_W-1:0]  cp0_waddr,
    input  logic [`EXC_DATA_W-1:0] cp0_wdata,

    input  logic [7:0]             irq,

    // Commit slot
    input  exc_pkg::exc_mask_t     exc_mask,
    input  logic [`EXC_ADDR_W-1:0] pc,

    // Decode mfc0
    input  logic [`CP0_REG_W-1:0]  cp0_raddr,
    output logic [`EXC_DATA_W-1:0] cp0_rdata,

    output exc_pkg::exc_code_e     exception,
    output logic                   mem_disable,
    output exc_pkg::redirect_t     redirect
);

    exc_pkg::cp0_status_t   status;
    exc_pkg::cp0_cause_t    cause;
    logic [`EXC_ADDR_W-1:0] epc;

    //////////////////////////////////////////////////////////////////////
    // CP0 state, decision, redirect
    //////////////////////////////////////////////////////////////////////

    cp0_regs cp0_regs0
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .we        (cp0_we),
        .waddr     (cp0_waddr),
        .wdata     (cp0_wdata),
        .irq       (irq),
        .exception (exception),
        .pc        (pc),
        .raddr     (cp0_raddr),
        .rdata     (cp0_rdata),
        .status    (status),
        .cause     (cause),
        .epc       (epc)
    );

    exception_handler exception_handler0
    (
        .status      (status),
        .cause       (cause),
        .exc_mask    (exc_mask),
        .pc          (pc),
        .exception   (exception),
        .mem_disable (mem_disable)
    );

    exception_redirect exception_redirect0
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .exception (exception),
        .epc       (epc),
        .redirect  (redirect)
    );

endmodule

`default_nettype wire

//--- tb_exc_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exc_cfg.svh"

module tb_exc_unit;

    logic                   clk;
    logic                   rst_n;
    logic                   cp0_we;
    logic [`CP0_REG_W-1:0]  cp0_waddr;
    logic [`EXC_DATA_W-1:0] cp0_wdata;
    logic [7:0]             irq;
    exc_pkg::exc_mask_t     exc_mask;
    logic [`EXC_ADDR_W-1:0] pc;
    logic [`CP0_REG_W-1:0]  cp0_raddr;
    logic [`EXC_DATA_W-1:0] cp0_rdata;
    exc_pkg::exc_code_e     exception;
    logic                   mem_disable;
    exc_pkg::redirect_t     redirect;

    integer seed = 32'h98e5_259f;
    string  test_name;
    int     errors;
    int     errors_at_open;
    int     tests_run;
    int     tests_failed;

    exc_unit dut0
    (
        .clk (clk), .rst_n (rst_n),
        .cp0_we (cp0_we), .cp0_waddr (cp0_waddr), .cp0_wdata (cp0_wdata),
        .irq (irq), .exc_mask (exc_mask), .pc (pc),
        .cp0_raddr (cp0_raddr), .cp0_rdata (cp0_rdata),
        .exception (exception), .mem_disable (mem_disable), .redirect (redirect)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Inputs change 2 ns past the edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            errors++;
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic open_test(input string name);
        test_name      = name;
        errors_at_open = errors;
        tests_run++;
    endtask

    task automatic close_test();
        if (errors == errors_at_open)
            $display("%s: ok", test_name);
        else
        begin
            tests_failed++;
            $display("%s: %0d errors", test_name, errors - errors_at_open);
        end
    endtask

    // Register holds the mtc0 word once this returns
    task automatic write_cp0(input logic [4:0] addr, input logic [31:0] data);
        next_cycle();
        cp0_we    = 1'b1;
        cp0_waddr = addr;
        cp0_wdata = data;
        next_cycle();
        cp0_we    = 1'b0;
    endtask

    // Read address set on the next cycle and sampled 1 ns later
    task automatic read_cp0(input logic [4:0] addr, output logic [31:0] data);
        next_cycle();
        cp0_raddr = addr;
        #1;
        data = cp0_rdata;
    endtask

    // Commit slot held for one cycle and sampled mid cycle
    task automatic drive_slot(input exc_pkg::exc_mask_t m, input logic [15:0] p);
        next_cycle();
        exc_mask = m;
        pc       = p;
        #8;
    endtask

    task automatic clear_slot();
        next_cycle();
        exc_mask = '0;
        pc       = '0;
    endtask

    // Syscall, illegal, trap, overflow, eret
    function automatic exc_pkg::exc_code_e expected_code(input exc_pkg::exc_mask_t m);
        if (m.syscall)
            return exc_pkg::EXC_SYSCALL;
        if (m.illegal)
            return exc_pkg::EXC_ILLEGAL;
        if (m.trap)
            return exc_pkg::EXC_TRAP;
        if (m.overflow)
            return exc_pkg::EXC_OVERFLOW;
        if (m.eret)
            return exc_pkg::EXC_ERET;
        return exc_pkg::EXC_NONE;
    endfunction

    // Flush is due in the first cycle after the exception and lasts one cycle
    task automatic wait_flush(input logic [15:0] target);
        int n;
        n = 0;
        while (!redirect.flush && n < 8)
        begin
            next_cycle();
            n++;
        end
        if (!redirect.flush)
        begin
            errors++;
            $display("%s: redirect flush never came after the exception", test_name);
        end
        else
        begin
            compare("flush delay", 0, n);
            compare("target", 32'(target), 32'(redirect.target));
            next_cycle();
            compare("flush width", 0, 32'(redirect.flush));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_state();
        logic [31:0] d;
        open_test("reset");
        read_cp0(`CP0_STATUS, d);
        compare("status", 0, d);
        read_cp0(`CP0_CAUSE, d);
        compare("cause", 0, d);
        read_cp0(`CP0_EPC, d);
        compare("epc", 0, d);
        compare("flush", 0, 32'(redirect.flush));
        compare("code", 32'(exc_pkg::EXC_NONE), 32'(exception));
        // No flag set yet
        compare("mem_disable", 0, 32'(mem_disable));
        close_test();
    endtask

    task automatic writeback_readback();
        logic [31:0]        r;
        logic [31:0]        d;
        exc_pkg::cp0_word_u w;
        exc_pkg::cp0_word_u e;
        open_test("writeback");
        for (int i = 0; i < 4; i++)
        begin
            r = $random(seed);
            w = r;
            write_cp0(`CP0_STATUS, w);
            // Only im, exl and ie stick
            e            = '0;
            e.status.im  = w.status.im;
            e.status.exl = w.status.exl;
            e.status.ie  = w.status.ie;
            read_cp0(`CP0_STATUS, d);
            compare("status", e, d);
            r = $random(seed);
            w = r;
            write_cp0(`CP0_CAUSE, w);
            // ip follows irq and irq is idle here
            e                = '0;
            e.cause.exc_code = w.cause.exc_code;
            read_cp0(`CP0_CAUSE, d);
            compare("cause", e, d);
            r = $random(seed);
            write_cp0(`CP0_EPC, {16'h0000, r[15:0]});
            read_cp0(`CP0_EPC, d);
            compare("epc", {16'h0000, r[15:0]}, d);
        end
        write_cp0(`CP0_STATUS, '0);
        close_test();
    endtask

    task automatic priority_order();
        logic [31:0]        r;
        exc_pkg::exc_mask_t m;
        open_test("priority");
        for (int i = 0; i < 16; i++)
        begin
            r = $random(seed);
            m = r[4:0];
            // First passes drop the top flag one at a time
            if (i < 5)
                m = 5'h1f >> i;
            if (m == '0)
                m.trap = 1'b1;
            drive_slot(m, r[31:16] | 16'h0004);
            compare("code", 32'(expected_code(m)), 32'(exception));
            compare("mem_disable", 1, 32'(mem_disable));
            // Bubble raises nothing
            drive_slot(m, '0);
            compare("bubble code", 32'(exc_pkg::EXC_NONE), 32'(exception));
        end
        clear_slot();
        close_test();
    endtask

    // Case 0 enabled, 1 other im bits, 2 ie clear, 3 exl set
    task automatic interrupt_gating();
        logic [31:0]        r;
        logic [7:0]         line;
        exc_pkg::exc_mask_t m;
        exc_pkg::cp0_word_u s;
        open_test("interrupt");
        for (int c = 0; c < 4; c++)
        begin
            r    = $random(seed);
            line = 8'h01 << r[2:0];
            m    = r[12:8];
            // Highest flag set so the interrupt has to beat it
            if (c == 0)
                m.syscall = 1'b1;
            next_cycle();
            irq          = line;
            s            = '0;
            s.status.im  = (c == 1) ? ~line : 8'hff;
            s.status.ie  = (c != 2);
            s.status.exl = (c == 3);
            write_cp0(`CP0_STATUS, s);
            drive_slot(m, 16'h0040);
            if (c == 0)
                compare("code", 32'(exc_pkg::EXC_INTERRUPT), 32'(exception));
            else
                compare("code", 32'(expected_code(m)), 32'(exception));
            clear_slot();
        end
        irq = '0;
        write_cp0(`CP0_STATUS, '0);
        close_test();
    endtask

    task automatic exception_entry();
        logic [31:0]        d;
        exc_pkg::cp0_word_u w;
        exc_pkg::exc_mask_t m;
        open_test("entry");
        m         = '0;
        m.syscall = 1'b1;
        drive_slot(m, 16'h2468);
        compare("code", 32'(exc_pkg::EXC_SYSCALL), 32'(exception));
        clear_slot();
        wait_flush(`EXC_VECTOR);
        read_cp0(`CP0_EPC, d);
        compare("epc", 32'h0000_2468, d);
        read_cp0(`CP0_CAUSE, d);
        w = d;
        compare("exc_code", 32'(exc_pkg::EXC_SYSCALL), 32'(w.cause.exc_code));
        read_cp0(`CP0_STATUS, d);
        w = d;
        compare("exl", 1, 32'(w.status.exl));
        close_test();
    endtask

    // EPC still holds 16'h2468 from the syscall above
    task automatic eret_exit();
        logic [31:0]        d;
        exc_pkg::cp0_word_u w;
        exc_pkg::exc_mask_t m;
        open_test("eret");
        m      = '0;
        m.eret = 1'b1;
        drive_slot(m, 16'h2470);
        compare("code", 32'(exc_pkg::EXC_ERET), 32'(exception));
        compare("mem_disable", 1, 32'(mem_disable));
        clear_slot();
        wait_flush(16'h2468);
        read_cp0(`CP0_STATUS, d);
        w = d;
        compare("exl", 0, 32'(w.status.exl));
        // Interrupt taken again with ie set
        next_cycle();
        irq         = 8'h20;
        w           = '0;
        w.status.im = 8'h20;
        w.status.ie = 1'b1;
        write_cp0(`CP0_STATUS, w);
        drive_slot('0, 16'h3000);
        compare("irq code", 32'(exc_pkg::EXC_INTERRUPT), 32'(exception));
        clear_slot();
        irq = '0;
        wait_flush(`EXC_VECTOR);
        read_cp0(`CP0_EPC, d);
        compare("irq epc", 32'h0000_3000, d);
        read_cp0(`CP0_CAUSE, d);
        w = d;
        compare("irq exc_code", 32'(exc_pkg::EXC_INTERRUPT), 32'(w.cause.exc_code));
        close_test();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        rst_n          = 1'b0;
        cp0_we         = 1'b0;
        cp0_waddr      = '0;
        cp0_wdata      = '0;
        irq            = '0;
        exc_mask       = '0;
        pc             = '0;
        cp0_raddr      = '0;
        errors         = 0;
        errors_at_open = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_name      = "";
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        reset_state();
        writeback_readback();
        priority_order();
        interrupt_gating();
        exception_entry();
        eret_exit();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- exc_unit.f
+incdir+.
exc_pkg.sv
cp0_regs.sv
exception_handler.sv
exception_redirect.sv
exc_unit.sv
tb_exc_unit.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TB_TOP    = tb_exc_unit
RTL_TOP   = exc_unit
FILELIST  = exc_unit.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The pipe hides the exit code, the log search decides
run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
